// ==== icache_pkg.sv ====
// ===================================================================
// Shared definitions for the four-way instruction cache
// The way count is fixed at four and is not a tuning knob
// Lines are 16 bytes, filled from four 32-bit memory beats
// Beat 0 of a refill lands in the low word of a line
// ===================================================================

package icache_pkg;

	// ===================================================================
	// Geometry
	// ===================================================================

	// Number of ways in every set
	localparam int icache_ways = 4;

	// Bytes held by one cache line
	localparam int line_bytes = 16;

	// Lowest address bit of the set index, just above the byte offset
	localparam int lobit = $clog2(line_bytes);

	// A line arrives from memory as this many 32-bit words
	localparam int beats_per_line = line_bytes / 4;

	// ===================================================================
	// Types
	// ===================================================================

	// Byte address on the fetch side
	typedef logic [31:0] code_address_t;

	// Encoded way number
	typedef logic [1:0] way_t;

	// One whole line, word 0 in bits 31:0
	typedef logic [line_bytes*8-1:0] cache_line_t;

	// Everything needed to write one refilled line into the arrays
	typedef struct packed {
		code_address_t address;
		way_t way;
		cache_line_t data;
	} line_fill_t;

endpackage

// ==== icache_tag_array.sv ====
// ===================================================================
// Tag store of the instruction cache, four ways by LINES sets
// LINES must be a power of two
// Tags are not reset, only the valid bits are cleared by rst or inv
// Reads are combinational at the index of look_addr, which the
// controller holds in a register
// ===================================================================
`timescale 1ns/10ps

module icache_tag_array #(
	parameter int LINES = 256,
	localparam int tag_lo = icache_pkg::lobit + $clog2(LINES)
) (
	input logic clk,
	input logic rst,
	input logic inv,
	input logic fill_wr,
	input icache_pkg::line_fill_t fill,
	input icache_pkg::code_address_t look_addr,
	output logic [icache_pkg::icache_ways-1:0][$bits(icache_pkg::code_address_t)-1:tag_lo] tags,
	output logic [icache_pkg::icache_ways-1:0] valids
);
	import icache_pkg::*;

	localparam int idx_w = $clog2(LINES);
	localparam int addr_hi = $bits(code_address_t) - 1;

	// Tag memory, meant to map onto distributed RAM
	logic [addr_hi:tag_lo] tag_mem [icache_ways][LINES];

	// One valid flag per way and set, kept in flip-flops so that a flush is a single cycle
	logic [icache_ways-1:0][LINES-1:0] valid_q;

	logic [idx_w-1:0] look_idx;
	logic [idx_w-1:0] fill_idx;

	assign look_idx = look_addr[lobit +: idx_w];
	assign fill_idx = fill.address[lobit +: idx_w];

	// The refill writes only the way that the controller picked
	always_ff @(posedge clk) begin
		if (fill_wr) begin
			tag_mem[fill.way][fill_idx] <= fill.address[addr_hi:tag_lo];
		end
	end

	// A flush drops every entry at once, a refill marks its own entry
	always_ff @(posedge clk) begin
		if (rst || inv) begin
			valid_q <= '0;
		end else if (fill_wr) begin
			valid_q[fill.way][fill_idx] <= 1'b1;
		end
	end

	// All four ways are presented together for the tag compare
	always_comb begin
		for (int w = 0; w < icache_ways; w++) begin
			tags[w] = tag_mem[w][look_idx];
			valids[w] = valid_q[w][look_idx];
		end
	end

	// The controller only refills while busy, and a flush is only legal while idle
	a_no_fill_on_inv: assert property (@(posedge clk) disable iff (rst) !(fill_wr && inv));

endmodule

// ==== icache_way_select.sv ====
// ===================================================================
// Hit detection and round-robin victim choice
// LINES must match the tag array
// The victim pointer of a set moves on by one on every refill of
// that set, whichever way was hit in between
// ===================================================================
`timescale 1ns/10ps

module icache_way_select #(
	parameter int LINES = 256,
	localparam int tag_lo = icache_pkg::lobit + $clog2(LINES)
) (
	input logic clk,
	input logic rst,
	input logic inv,
	input icache_pkg::code_address_t look_addr,
	input logic [icache_pkg::icache_ways-1:0][$bits(icache_pkg::code_address_t)-1:tag_lo] tags,
	input logic [icache_pkg::icache_ways-1:0] valids,
	input logic fill_wr,
	input icache_pkg::line_fill_t fill,
	output logic hit,
	output icache_pkg::way_t hit_way,
	output icache_pkg::way_t victim_way
);
	import icache_pkg::*;

	localparam int idx_w = $clog2(LINES);
	localparam int addr_hi = $bits(code_address_t) - 1;

	logic [idx_w-1:0] look_idx;
	logic [idx_w-1:0] fill_idx;
	logic [addr_hi:tag_lo] look_tag;
	logic [icache_ways-1:0] match;

	// Round-robin pointer of each set
	way_t [LINES-1:0] rr_q;

	assign look_idx = look_addr[lobit +: idx_w];
	assign fill_idx = fill.address[lobit +: idx_w];
	assign look_tag = look_addr[addr_hi:tag_lo];

	// ===================================================================
	// Tag compare
	// ===================================================================

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < icache_ways; w++) begin
			match[w] = valids[w] && (tags[w] == look_tag);
			// At most one way matches, so the encoder needs no priority
			if (match[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign hit = |match;

	// ===================================================================
	// Victim pointers
	// ===================================================================

	always_ff @(posedge clk) begin
		if (rst || inv) begin
			rr_q <= '0;
		end else if (fill_wr) begin
			rr_q[fill_idx] <= way_t'(rr_q[fill_idx] + 1'b1);
		end
	end

	assign victim_way = rr_q[look_idx];

	// A line is only refilled after a miss, so one set never holds a tag twice
	a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

endmodule

// ==== icache_data_array.sv ====
// ===================================================================
// Line storage of the instruction cache
// A refill writes the whole 16-byte line in one cycle
// The read is combinational, so the word follows look_addr and
// sel_way within the same cycle
// ===================================================================
`timescale 1ns/10ps

module icache_data_array #(
	parameter int LINES = 256
) (
	input logic clk,
	input logic fill_wr,
	input icache_pkg::line_fill_t fill,
	input icache_pkg::code_address_t look_addr,
	input icache_pkg::way_t sel_way,
	output logic [31:0] word
);
	import icache_pkg::*;

	localparam int idx_w = $clog2(LINES);

	// Line memory of every way, no reset
	cache_line_t line_mem [icache_ways][LINES];

	logic [idx_w-1:0] look_idx;
	logic [idx_w-1:0] fill_idx;
	cache_line_t rd_line;

	assign look_idx = look_addr[lobit +: idx_w];
	assign fill_idx = fill.address[lobit +: idx_w];

	always_ff @(posedge clk) begin
		if (fill_wr) begin
			line_mem[fill.way][fill_idx] <= fill.data;
		end
	end

	// Line of the chosen way, then the word that the offset bits point at
	assign rd_line = line_mem[sel_way][look_idx];
	assign word = rd_line[look_addr[lobit-1:2]*32 +: 32];

endmodule

// ==== icache_ctrl.sv ====
// ===================================================================
// Control FSM of the instruction cache
// One request at a time, a req while busy is not allowed
// A hit answers in the lookup cycle, a miss asks memory for the line,
// takes four beats with any gaps, refills, then answers
// Memory must not send beats that were not asked for
// ===================================================================
`timescale 1ns/10ps

module icache_ctrl (
	input logic clk,
	input logic rst,
	input logic req,
	input icache_pkg::code_address_t addr,
	output logic busy,
	output logic rsp_valid,
	output icache_pkg::code_address_t look_addr,
	input logic hit,
	input icache_pkg::way_t hit_way,
	input icache_pkg::way_t victim_way,
	output icache_pkg::way_t sel_way,
	output logic mem_req,
	output icache_pkg::code_address_t mem_addr,
	input logic mem_valid,
	input logic [31:0] mem_data,
	output logic fill_wr,
	output icache_pkg::line_fill_t fill
);
	import icache_pkg::*;

	localparam int beat_w = $clog2(beats_per_line);

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_wait,
		st_fill,
		st_respond
	} state_t;

	state_t state_q;
	logic [beat_w-1:0] beat_q;

	// ===================================================================
	// State and beat counter
	// ===================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_idle;
			beat_q <= '0;
		end else begin
			case (state_q)
				st_idle: begin
					if (req) begin
						state_q <= st_lookup;
					end
				end
				st_lookup: begin
					// The hit was already answered in this cycle
					if (hit) begin
						state_q <= st_idle;
					end else begin
						state_q <= st_wait;
						beat_q <= '0;
					end
				end
				st_wait: begin
					if (mem_valid) begin
						beat_q <= beat_q + 1'b1;
						if (beat_q == beat_w'(beats_per_line - 1)) begin
							state_q <= st_fill;
						end
					end
				end
				st_fill: begin
					state_q <= st_respond;
				end
				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// ===================================================================
	// Address and refill registers
	// ===================================================================

	always_ff @(posedge clk) begin
		if (state_q == st_idle && req) begin
			look_addr <= addr;
		end
		// The victim is taken now, before the refill moves the pointer
		if (state_q == st_lookup && !hit) begin
			fill.address <= look_addr;
			fill.way <= victim_way;
		end
		// Beats come in order, so the counter gives the word slot
		if (state_q == st_wait && mem_valid) begin
			fill.data[beat_q*32 +: 32] <= mem_data;
		end
	end

	// Outputs decoded from the state
	assign busy = (state_q != st_idle);
	assign rsp_valid = (state_q == st_lookup && hit) || (state_q == st_respond);
	assign mem_req = (state_q == st_lookup) && !hit;
	assign mem_addr = {look_addr[$bits(code_address_t)-1:lobit], {lobit{1'b0}}};
	assign fill_wr = (state_q == st_fill);

	// After a refill the answer comes from the way that was just written
	assign sel_way = (state_q == st_respond) ? fill.way : hit_way;

	// The fetch side waits for the answer before the next request
	a_req_when_idle: assert property (@(posedge clk) disable iff (rst) req |-> !busy);

	// Memory only returns beats for the miss in flight
	a_beat_in_wait: assert property (
		@(posedge clk) disable iff (rst) mem_valid |-> (state_q == st_wait)
	);

endmodule

// ==== icache_top.sv ====
// ===================================================================
// Top level of the four-way instruction cache
// LINES sets the number of sets and must be a power of two
// rsp_data is only meaningful while rsp_valid is high
// inv may only pulse while busy is low
// ===================================================================
`timescale 1ns/10ps

module icache_top #(
	parameter int LINES = 256
) (
	input logic clk,
	input logic rst,
	input logic inv,
	input logic req,
	input icache_pkg::code_address_t addr,
	output logic rsp_valid,
	output logic [31:0] rsp_data,
	output logic busy,
	output logic mem_req,
	output icache_pkg::code_address_t mem_addr,
	input logic mem_valid,
	input logic [31:0] mem_data
);
	import icache_pkg::*;

	localparam int tag_lo = lobit + $clog2(LINES);

	code_address_t look_addr;
	logic [icache_ways-1:0][$bits(code_address_t)-1:tag_lo] tags;
	logic [icache_ways-1:0] valids;
	logic hit;
	way_t hit_way;
	way_t victim_way;
	way_t sel_way;
	logic fill_wr;
	line_fill_t fill;

	icache_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.req(req),
		.addr(addr),
		.busy(busy),
		.rsp_valid(rsp_valid),
		.look_addr(look_addr),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.sel_way(sel_way),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_valid(mem_valid),
		.mem_data(mem_data),
		.fill_wr(fill_wr),
		.fill(fill)
	);

	icache_tag_array #(.LINES(LINES)) u_tags (
		.clk(clk),
		.rst(rst),
		.inv(inv),
		.fill_wr(fill_wr),
		.fill(fill),
		.look_addr(look_addr),
		.tags(tags),
		.valids(valids)
	);

	icache_way_select #(.LINES(LINES)) u_ways (
		.clk(clk),
		.rst(rst),
		.inv(inv),
		.look_addr(look_addr),
		.tags(tags),
		.valids(valids),
		.fill_wr(fill_wr),
		.fill(fill),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way)
	);

	// The selected word goes straight out as the fetch response
	icache_data_array #(.LINES(LINES)) u_data (
		.clk(clk),
		.fill_wr(fill_wr),
		.fill(fill),
		.look_addr(look_addr),
		.sel_way(sel_way),
		.word(rsp_data)
	);

endmodule

// ==== tb_icache.sv ====
// ======================================================================
// Directed testbench for the four-way instruction cache
// The memory model answers every mem_req with four in-order beats and
// 0 to 3 idle cycles between them, each word is its byte address
// XOR 32'h5a5a0000, so every expected fetch result follows from that
// Runs with LINES = 256, which puts the set index in bits 11:4
// ======================================================================
`timescale 1ns/10ps

module tb_icache;
	import icache_pkg::*;

	localparam int LINES = 256;
	localparam int tag_lo = lobit + $clog2(LINES);
	localparam int rsp_timeout = 60;
	localparam logic [31:0] data_mask = 32'h5a5a0000;
	// Galois feedback for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] lfsr_taps = 32'h80200003;
	localparam code_address_t cold_addr = 32'h0000_1248;

	logic clk;
	logic rst;
	logic inv;
	logic req;
	code_address_t addr;
	logic rsp_valid;
	logic [31:0] rsp_data;
	logic busy;
	logic mem_req;
	code_address_t mem_addr;
	logic mem_valid;
	logic [31:0] mem_data;

	int mem_req_count;
	code_address_t last_mem_addr;
	logic [31:0] gap_lfsr;
	logic [31:0] addr_lfsr;

	// Reference model of the tag store and the victim pointers
	logic [31:tag_lo] model_tag [LINES][icache_ways];
	logic model_valid [LINES][icache_ways];
	int model_rr [LINES];

	icache_top #(.LINES(LINES)) u_dut (
		.clk(clk),
		.rst(rst),
		.inv(inv),
		.req(req),
		.addr(addr),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.busy(busy),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_valid(mem_valid),
		.mem_data(mem_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	// Steps the LFSR once per bit and collects the bits that fall out
	function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
		end
		return bits;
	endfunction

	// Memory content rule, applied to the word that holds the byte address
	function automatic logic [31:0] expected_word(input code_address_t a);
		return {a[31:2], 2'b00} ^ data_mask;
	endfunction

	function automatic void clear_model();
		for (int s = 0; s < LINES; s++) begin
			model_rr[s] = 0;
			for (int w = 0; w < icache_ways; w++) begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
	endfunction

	// Returns 1 on a predicted miss and refills the model like the cache would
	function automatic logic predict_miss(input code_address_t a);
		int set_idx;
		int way;
		set_idx = int'(a[tag_lo-1:lobit]);
		for (int w = 0; w < icache_ways; w++) begin
			if (model_valid[set_idx][w] && model_tag[set_idx][w] == a[31:tag_lo]) begin
				return 1'b0;
			end
		end
		way = model_rr[set_idx];
		model_tag[set_idx][way] = a[31:tag_lo];
		model_valid[set_idx][way] = 1'b1;
		model_rr[set_idx] = (way + 1) % icache_ways;
		return 1'b1;
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Test failures found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// ======================================================================
	// Memory model
	// ======================================================================

	initial begin : memory_model
		int gap;
		code_address_t line;
		mem_valid <= 1'b0;
		mem_data <= '0;
		mem_req_count = 0;
		last_mem_addr = '0;
		gap_lfsr = 32'ha2e8;
		forever begin
			@(negedge clk);
			if (mem_req) begin
				mem_req_count++;
				last_mem_addr = mem_addr;
				line = mem_addr;
				// The cache enters its beat wait on this edge
				@(posedge clk);
				for (int b = 0; b < beats_per_line; b++) begin
					gap = int'(take_bits(gap_lfsr, 2));
					repeat (gap) begin
						mem_valid <= 1'b0;
						@(posedge clk);
					end
					mem_valid <= 1'b1;
					mem_data <= (line + 32'(4 * b)) ^ data_mask;
					@(posedge clk);
				end
				mem_valid <= 1'b0;
			end
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	// One request, then the response is sampled on falling edges
	task automatic fetch(input code_address_t a, input logic expect_miss);
		int count_before;
		int waited;
		count_before = mem_req_count;
		@(posedge clk);
		req <= 1'b1;
		addr <= a;
		@(posedge clk);
		req <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!rsp_valid) begin
			if (waited == rsp_timeout) begin
				$display("Timeout: no rsp_valid for the fetch of %h after %0d cycles",
					a, waited);
				$display("Test failures found");
				$fatal(1, "Fetch did not complete");
			end
			// The cache stays busy for the whole miss
			check(32'(busy), 32'(1), "busy while waiting");
			waited++;
			@(negedge clk);
		end
		check(32'(busy), 32'(1), "busy with rsp_valid");
		check(rsp_data, expected_word(a), "rsp_data");
		check(mem_req_count - count_before, expect_miss ? 1 : 0, "mem_req count");
		if (expect_miss) begin
			check(last_mem_addr, a & ~32'(line_bytes - 1), "mem_addr");
		end else begin
			// A hit answers in the cycle right after req
			check(waited, 0, "hit latency");
		end
	endtask

	task automatic pulse_inv();
		@(posedge clk);
		inv <= 1'b1;
		@(posedge clk);
		inv <= 1'b0;
	endtask

	task automatic cold_miss();
		fetch(cold_addr, 1'b1);
	endtask

	task automatic hit_whole_line();
		for (int w = 0; w < beats_per_line; w++) begin
			fetch({cold_addr[31:lobit], {lobit{1'b0}}} + 32'(4 * w), 1'b0);
		end
	endtask

	// Five tags in set 0x20, so the fifth pushes out the first one filled
	task automatic evict_oldest_way();
		for (int t = 1; t <= 4; t++) begin
			fetch(32'(t << 12) | 32'h204, 1'b1);
		end
		for (int t = 1; t <= 4; t++) begin
			fetch(32'(t << 12) | 32'h204, 1'b0);
		end
		fetch(32'(5 << 12) | 32'h204, 1'b1);
		for (int t = 2; t <= 4; t++) begin
			fetch(32'(t << 12) | 32'h204, 1'b0);
		end
		fetch(32'(1 << 12) | 32'h204, 1'b1);
	endtask

	task automatic flush_then_refetch();
		fetch(cold_addr, 1'b0);
		pulse_inv();
		fetch(cold_addr, 1'b1);
		fetch(cold_addr, 1'b0);
	endtask

	// Eight tags over four sets keep evictions frequent
	task automatic random_fetches();
		logic [31:0] tag_bits;
		logic [31:0] set_bits;
		logic [31:0] word_bits;
		code_address_t a;
		pulse_inv();
		clear_model();
		repeat (200) begin
			tag_bits = take_bits(addr_lfsr, 3);
			set_bits = take_bits(addr_lfsr, 2);
			word_bits = take_bits(addr_lfsr, 2);
			a = 32'h0004_0000 | (tag_bits << tag_lo) | (set_bits << lobit) | (word_bits << 2);
			fetch(a, predict_miss(a));
		end
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin : main
		rst <= 1'b1;
		inv <= 1'b0;
		req <= 1'b0;
		addr <= '0;
		addr_lfsr = 32'ha2e8;
		clear_model();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check(32'(busy), 32'(0), "busy after reset");
		check(32'(rsp_valid), 32'(0), "rsp_valid after reset");
		check(32'(mem_req), 32'(0), "mem_req after reset");
		cold_miss();
		hit_whole_line();
		evict_oldest_way();
		flush_then_refetch();
		random_fetches();
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== tb.f ====
icache_pkg.sv
icache_tag_array.sv
icache_way_select.sv
icache_data_array.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compiles the instruction cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_icache -o sim_icache

# The log decides the result, so the simulator's own exit status is not used here
./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q 'Test failures found' sim.log || ! grep -q 'All tests passed!' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
